// File: dv/avalonMemModel.sv
module avalonMemModel #(
    parameter logic [31:0] progBase = 32'hBFC00000,
    parameter int progWords = 16,
    parameter int dataWords = 64
) (
    input  logic        clk,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic        waitrequest,
    output logic [31:0] readdata
);

    localparam int progBits = $clog2(progWords);
    localparam int dataBits = $clog2(dataWords);

    logic [31:0] progMem [progWords];
    logic [31:0] dataMem [dataWords];
    integer      seed = 32'h6078;
    int          stallLeft;
    logic        busy;

    // Program window at progBase, data window from address zero
    function automatic logic [31:0] readWord(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - progBase;
        if (offset < progWords * 4) begin
            return progMem[offset[progBits+1:2]];
        end else if (addr < dataWords * 4) begin
            return dataMem[addr[dataBits+1:2]];
        end
        return 32'h0;
    endfunction

    task automatic clearMemory();
        for (int i = 0; i < progWords; i++) begin
            progMem[i] = 32'h0;
        end
        for (int i = 0; i < dataWords; i++) begin
            dataMem[i] = 32'h0;
        end
    endtask

    task automatic loadWord(input int idx, input logic [31:0] word);
        progMem[idx] = word;
    endtask

    initial begin
        waitrequest = 1'b0;
        readdata = 32'h0;
        busy = 1'b0;
        stallLeft = 0;
    end

    // A new request picks 0 to 3 stall cycles, then counts them down
    always @(negedge clk) begin
        if (!(read || write)) begin
            busy = 1'b0;
            waitrequest = 1'b0;
        end else begin
            if (!busy) begin
                busy = 1'b1;
                stallLeft = $random(seed) & 3;
            end
            waitrequest = (stallLeft != 0);
            if (stallLeft != 0) begin
                stallLeft = stallLeft - 1;
            end
            readdata = readWord(address);
        end
    end

    always @(posedge clk) begin
        if (write && !waitrequest && address < dataWords * 4) begin
            dataMem[address[dataBits+1:2]] <= writedata;
        end
    end

endmodule

// File: dv/mipsCpuBusTb.sv
module mipsCpuBusTb
    import mipsPkg::*;
();

    localparam logic [31:0] resetVector = 32'hBFC00000;
    localparam int numTests = 6;
    localparam int progLen = 12;
    localparam int quietCycles = 20;
    // Worst case per instruction stays well under 17 cycles
    localparam int timeoutCycles = numTests * progLen * 17;
    localparam logic [31:0] noMemCheck = 32'hFFFF_FFFF;

    localparam logic [4:0] rT0 = 5'd8;
    localparam logic [4:0] rT1 = 5'd9;
    localparam logic [4:0] rT2 = 5'd10;
    localparam logic [4:0] rT3 = 5'd11;
    localparam logic [4:0] rT4 = 5'd12;
    localparam logic [31:0] jrZero = 32'h0000_0008;
    localparam logic [31:0] nop = 32'h0000_0000;

    logic        clk = 1'b0;
    logic        reset;
    logic        active;
    logic [31:0] registerV0;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic        waitrequest;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata;

    logic [31:0] programTable [numTests*progLen];
    logic [31:0] expectV0 [numTests];
    logic [31:0] memAddr [numTests];
    logic [31:0] memWord [numTests];
    string       testNames [numTests];
    int          cycleCount = 0;
    int          passCount;
    int          failCount;

    always #4 clk = ~clk;

    mipsCpuBus #(
        .resetVector(resetVector)
    ) u_mipsCpuBus (
        .clk(clk), .reset(reset),
        .active(active), .registerV0(registerV0),
        .address(address), .read(read), .write(write),
        .waitrequest(waitrequest), .writedata(writedata),
        .byteenable(byteenable), .readdata(readdata)
    );

    avalonMemModel #(
        .progBase(resetVector)
    ) u_avalonMemModel (
        .clk(clk), .address(address), .read(read), .write(write),
        .writedata(writedata), .waitrequest(waitrequest), .readdata(readdata)
    );

    function automatic logic [31:0] instrR(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sa,
                                           input funcT fn);
        return {6'b000000, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] instrI(input opcodeT op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] instrJ(input logic [31:0] target);
        return {opJ, target[27:2]};
    endfunction

    task automatic loadTable();
        programTable = '{
            // rtype: ADDU, AND, OR, XOR, SLL, SUBU, SRA, SRL chain
            instrI(opAddiu, regZero, rT0, 16'h1234), instrI(opAddiu, regZero, rT1, 16'h0FF0),
            instrR(rT0, rT1, rT2, 5'd0, fnAddu), instrR(rT0, rT1, rT3, 5'd0, fnAnd),
            instrR(rT2, rT3, rT2, 5'd0, fnOr), instrR(rT2, rT1, rT2, 5'd0, fnXor),
            instrR(regZero, rT2, rT2, 5'd4, fnSll), instrR(regZero, rT2, rT3, 5'd0, fnSubu),
            instrR(regZero, rT3, rT3, 5'd4, fnSra), instrR(regZero, rT3, regV0, 5'd8, fnSrl),
            jrZero, nop,
            // immediate: logic immediates are zero-extended
            instrI(opAddiu, regZero, rT0, 16'hFFFB), instrI(opAndi, rT0, rT1, 16'h8F0F),
            instrI(opXori, rT1, rT1, 16'h8001), instrI(opLui, regZero, regV0, 16'h1234),
            instrI(opOri, regV0, regV0, 16'h8765), instrR(regV0, rT1, regV0, 5'd0, fnAddu),
            instrI(opOri, regZero, rT2, 16'h9000), instrR(regV0, rT2, regV0, 5'd0, fnAddu),
            jrZero, nop, nop, nop,
            // compare: -3 against 7 and 5
            instrI(opAddiu, regZero, rT0, 16'hFFFD), instrI(opAddiu, regZero, rT1, 16'h0007),
            instrR(rT0, rT1, rT2, 5'd0, fnSlt), instrI(opSlti, rT0, rT3, 16'h0005),
            instrR(rT0, rT1, rT4, 5'd0, fnSltu), instrR(regZero, rT2, regV0, 5'd2, fnSll),
            instrR(regZero, rT3, rT3, 5'd1, fnSll), instrR(regV0, rT3, regV0, 5'd0, fnOr),
            instrR(regV0, rT4, regV0, 5'd0, fnOr), jrZero, nop, nop,
            // memory: two stores at 0x48 and 0x4C, then read both back
            instrI(opLui, regZero, rT0, 16'hCAFE), instrI(opOri, rT0, rT0, 16'hBABE),
            instrI(opAddiu, regZero, rT1, 16'h0040), instrI(opSw, rT1, rT0, 16'h0008),
            instrI(opAddiu, regZero, rT2, 16'h0011), instrI(opSw, rT1, rT2, 16'h000C),
            instrI(opLw, rT1, regV0, 16'h0008), instrI(opLw, rT1, rT3, 16'h000C),
            instrR(regV0, rT3, regV0, 5'd0, fnAddu), jrZero, nop, nop,
            // branch: path adds 1, 2, 4, 8 and skips 64 and 128
            instrI(opAddiu, regZero, rT0, 16'h0005), instrI(opBeq, rT0, rT0, 16'h0002),
            instrI(opAddiu, regV0, regV0, 16'h0001), instrI(opAddiu, regV0, regV0, 16'h0040),
            instrI(opBne, rT0, rT0, 16'h0005), instrI(opAddiu, regV0, regV0, 16'h0002),
            instrI(opAddiu, regV0, regV0, 16'h0004), instrJ(resetVector + 32'd40),
            instrI(opAddiu, regV0, regV0, 16'h0008), instrI(opAddiu, regV0, regV0, 16'h0080),
            jrZero, nop,
            // halt
            instrI(opAddiu, regZero, regV0, 16'h0077), instrI(opAddiu, regV0, regV0, 16'h0001),
            jrZero, nop, nop, nop, nop, nop, nop, nop, nop, nop
        };
        expectV0 = '{32'h00FF_FFD2, 32'h1235_266F, 32'h0000_0006,
                     32'hCAFE_BACF, 32'h0000_000F, 32'h0000_0078};
        memAddr = '{noMemCheck, noMemCheck, noMemCheck, 32'h48, noMemCheck, noMemCheck};
        memWord = '{32'h0, 32'h0, 32'h0, 32'hCAFE_BABE, 32'h0, 32'h0};
        testNames = '{"rtype", "immediate", "compare", "memory", "branch", "halt"};
    endtask

    task automatic runTest(input int t);
        int   busHits;
        logic ok;
        logic [31:0] stored;
        busHits = 0;
        ok = 1'b1;
        @(negedge clk);
        reset = 1'b1;
        u_avalonMemModel.clearMemory();
        for (int i = 0; i < progLen; i++) begin
            u_avalonMemModel.loadWord(i, programTable[t*progLen + i]);
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;
        while (active) begin
            @(negedge clk);
            // Word transfers only, all four lanes on
            if ((read || write) && byteenable !== 4'b1111) begin
                $display("ERROR at %0t: %s: byteenable is %b during a bus request",
                         $time, testNames[t], byteenable);
                ok = 1'b0;
            end
        end
        if (registerV0 !== expectV0[t]) begin
            $display("ERROR at %0t: %s: $v0 is %h, expected %h",
                     $time, testNames[t], registerV0, expectV0[t]);
            ok = 1'b0;
        end
        if (memAddr[t] != noMemCheck) begin
            stored = u_avalonMemModel.readWord(memAddr[t]);
            if (stored !== memWord[t]) begin
                $display("ERROR at %0t: %s: memory at %h is %h, expected %h",
                         $time, testNames[t], memAddr[t], stored, memWord[t]);
                ok = 1'b0;
            end
        end
        // Halted core must stay off the bus
        repeat (quietCycles) begin
            @(negedge clk);
            if (read || write) begin
                busHits++;
            end
        end
        if (busHits != 0) begin
            $display("%s: the core kept issuing bus requests after it halted", testNames[t]);
            ok = 1'b0;
        end
        if (ok) begin
            passCount++;
            $display("PASS %s", testNames[t]);
        end else begin
            failCount++;
            $display("FAIL %s", testNames[t]);
        end
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout after %0d cycles: the core never halted", cycleCount);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        passCount = 0;
        failCount = 0;
        loadTable();
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        $display("%0d of %0d tests passed, %0d failed", passCount, numTests, failCount);
        if (failCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: hdl/alu.sv
module alu
    import mipsPkg::*;
(
    input  aluOpT                aluOp,
    input  logic [dataWidth-1:0] aluA,
    input  logic [dataWidth-1:0] aluB,
    input  logic [4:0]           shamt,

    output logic [dataWidth-1:0] aluResult,
    output logic                 aluZero
);

    always_comb begin
        case (aluOp)
            aluAdd:  aluResult = aluA + aluB;
            aluSub:  aluResult = aluA - aluB;
            aluAnd:  aluResult = aluA & aluB;
            aluOr:   aluResult = aluA | aluB;
            aluXor:  aluResult = aluA ^ aluB;
            aluSlt: begin
                aluResult = {31'b0, $signed(aluA) < $signed(aluB)};
            end
            aluSltu: begin
                aluResult = {31'b0, aluA < aluB};
            end
            // Shifts work on operand B, rt in the encoding
            aluSll:  aluResult = aluB << shamt;
            aluSrl:  aluResult = aluB >> shamt;
            aluSra:  aluResult = $signed(aluB) >>> shamt;
            aluLui:  aluResult = {aluB[15:0], 16'b0};
            aluPassA: aluResult = aluA;
            default: aluResult = aluA;
        endcase
    end

    assign aluZero = (aluResult == '0);

endmodule

// File: hdl/cpuController.sv
module cpuController
    import mipsPkg::*;
#(
    parameter logic [31:0] resetVector = 32'hBFC00000
) (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    waitrequest,
    input  logic [dataWidth-1:0]    readdata,
    output logic [dataWidth-1:0]    address,
    output logic                    read,
    output logic                    write,
    output logic [dataWidth-1:0]    writedata,
    output logic [3:0]              byteenable,
    output logic                    active,

    output logic [dataWidth-1:0]    instr,
    input  logic [dataWidth-1:0]    aluResult,
    input  logic                    aluZero,
    input  logic [dataWidth-1:0]    rtData,
    input  logic [dataWidth-1:0]    rsData,

    input  logic                    isLoad,
    input  logic                    isStore,
    input  logic                    isBranchEq,
    input  logic                    isBranchNe,
    input  logic                    isJump,
    input  logic                    isJumpReg,
    input  logic                    regWrite,
    input  logic [regAddrWidth-1:0] destReg,
    input  logic [dataWidth-1:0]    branchOffset,
    input  logic [27:0]             jumpTarget,

    output logic                    wrEn,
    output logic [regAddrWidth-1:0] wrAddr,
    output logic [dataWidth-1:0]    wrData
);

    cpuStateT             state;
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pcPlus4;
    logic [dataWidth-1:0] pendingTarget;
    logic [dataWidth-1:0] nextTarget;
    logic                 branchPending;
    logic                 inDelaySlot;
    logic                 takeBranch;
    logic                 memAccess;

    logic [dataWidth-1:0] aluOut;
    logic [dataWidth-1:0] storeData;
    logic [dataWidth-1:0] loadData;

    assign pcPlus4 = pc + 32'd4;
    assign memAccess = isLoad || isStore;

    assign takeBranch = isJump || isJumpReg
                     || (isBranchEq && aluZero)
                     || (isBranchNe && !aluZero);

    always_comb begin
        if (isJumpReg) begin
            nextTarget = rsData;
        end else if (isJump) begin
            nextTarget = {pcPlus4[31:28], jumpTarget};
        end else begin
            nextTarget = pcPlus4 + branchOffset;
        end
    end

    // Bus requests follow the state, so they stay put while stalled
    assign read = (state == sFetch && pc != '0) || (state == sMem && isLoad);
    assign write = (state == sMem) && isStore;
    assign address = (state == sMem) ? {aluOut[31:2], 2'b00} : pc;
    assign writedata = storeData;
    assign byteenable = 4'b1111;

    assign wrEn = (state == sWriteback) && regWrite;
    assign wrAddr = destReg;
    assign wrData = isLoad ? loadData : aluOut;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= sFetch;
            pc <= resetVector;
            active <= 1'b1;
            branchPending <= 1'b0;
            inDelaySlot <= 1'b0;
        end else begin
            case (state)
                sFetch: begin
                    if (pc == '0) begin
                        state <= sHalted;
                        active <= 1'b0;
                    end else if (!waitrequest) begin
                        state <= sDecode;
                    end
                end
                sDecode: state <= sExec;
                sExec: begin
                    state <= sMem;
                    if (takeBranch) begin
                        branchPending <= 1'b1;
                    end
                end
                sMem: begin
                    if (!memAccess || !waitrequest) begin
                        state <= sWriteback;
                    end
                end
                sWriteback: begin
                    state <= sFetch;
                    // Delay slot done, so the held target takes over now
                    if (inDelaySlot) begin
                        pc <= pendingTarget;
                    end else begin
                        pc <= pcPlus4;
                    end
                    inDelaySlot <= branchPending;
                    branchPending <= 1'b0;
                end
                sHalted: state <= sHalted;
                default: state <= sFetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sFetch && read && !waitrequest) begin
            instr <= readdata;
        end
        if (state == sExec) begin
            aluOut <= aluResult;
            storeData <= rtData;
            if (takeBranch) begin
                pendingTarget <= nextTarget;
            end
        end
        if (state == sMem && isLoad && !waitrequest) begin
            loadData <= readdata;
        end
    end

endmodule

// File: hdl/instrDecoder.sv
module instrDecoder
    import mipsPkg::*;
(
    input  logic [dataWidth-1:0]    instr,
    input  logic [dataWidth-1:0]    rsData,
    input  logic [dataWidth-1:0]    rtData,

    output logic [regAddrWidth-1:0] rsAddr,
    output logic [regAddrWidth-1:0] rtAddr,
    output logic [dataWidth-1:0]    aluA,
    output logic [dataWidth-1:0]    aluB,
    output logic [4:0]              shamt,
    output aluOpT                   aluOp,
    output logic [regAddrWidth-1:0] destReg,

    output logic                    regWrite,
    output logic                    isLoad,
    output logic                    isStore,
    output logic                    isBranchEq,
    output logic                    isBranchNe,
    output logic                    isJump,
    output logic                    isJumpReg,

    output logic [dataWidth-1:0]    branchOffset,
    output logic [27:0]             jumpTarget
);

    logic [5:0]           opcode;
    logic [5:0]           funct;
    logic [dataWidth-1:0] signExtImm;
    logic [dataWidth-1:0] zeroExtImm;
    logic                 isRType;
    logic                 useZeroExt;

    assign opcode = instr[31:26];
    assign funct = instr[5:0];
    assign rsAddr = instr[25:21];
    assign rtAddr = instr[20:16];
    assign shamt = instr[10:6];

    assign signExtImm = {{16{instr[15]}}, instr[15:0]};
    assign zeroExtImm = {16'b0, instr[15:0]};
    assign branchOffset = {{14{instr[15]}}, instr[15:0], 2'b00};
    assign jumpTarget = {instr[25:0], 2'b00};

    assign isRType = (opcode == opRType);
    assign useZeroExt = (opcode == opAndi) || (opcode == opOri) || (opcode == opXori);

    assign destReg = isRType ? instr[15:11] : instr[20:16];

    assign isLoad = (opcode == opLw);
    assign isStore = (opcode == opSw);
    assign isBranchEq = (opcode == opBeq);
    assign isBranchNe = (opcode == opBne);
    assign isJump = (opcode == opJ);
    assign isJumpReg = isRType && (funct == fnJr);

    assign aluA = rsData;

    // Branches compare rs with rt, so they take rt as well
    always_comb begin
        if (isRType || isBranchEq || isBranchNe) begin
            aluB = rtData;
        end else if (useZeroExt) begin
            aluB = zeroExtImm;
        end else begin
            aluB = signExtImm;
        end
    end

    always_comb begin
        aluOp = aluPassA;
        regWrite = 1'b0;
        case (opcode)
            opRType: begin
                regWrite = 1'b1;
                case (funct)
                    fnAddu: aluOp = aluAdd;
                    fnSubu: aluOp = aluSub;
                    fnAnd:  aluOp = aluAnd;
                    fnOr:   aluOp = aluOr;
                    fnXor:  aluOp = aluXor;
                    fnSlt:  aluOp = aluSlt;
                    fnSltu: aluOp = aluSltu;
                    fnSll:  aluOp = aluSll;
                    fnSrl:  aluOp = aluSrl;
                    fnSra:  aluOp = aluSra;
                    default: regWrite = 1'b0;
                endcase
            end
            opAddiu, opLw: begin
                aluOp = aluAdd;
                regWrite = 1'b1;
            end
            opSw:    aluOp = aluAdd;
            opBeq, opBne: aluOp = aluSub;
            opAndi: begin
                aluOp = aluAnd;
                regWrite = 1'b1;
            end
            opOri: begin
                aluOp = aluOr;
                regWrite = 1'b1;
            end
            opXori: begin
                aluOp = aluXor;
                regWrite = 1'b1;
            end
            opSlti: begin
                aluOp = aluSlt;
                regWrite = 1'b1;
            end
            opSltiu: begin
                aluOp = aluSltu;
                regWrite = 1'b1;
            end
            opLui: begin
                aluOp = aluLui;
                regWrite = 1'b1;
            end
            default: regWrite = 1'b0;
        endcase
    end

endmodule

// File: hdl/mipsCpuBus.sv
module mipsCpuBus
    import mipsPkg::*;
#(
    parameter logic [31:0] resetVector = 32'hBFC00000
) (
    input  logic        clk,
    input  logic        reset,

    output logic        active,
    output logic [31:0] registerV0,

    // Avalon-MM master
    output logic [31:0] address,
    output logic        read,
    output logic        write,
    input  logic        waitrequest,
    output logic [31:0] writedata,
    output logic [3:0]  byteenable,
    input  logic [31:0] readdata
);

    logic [dataWidth-1:0]    instr;
    logic [regAddrWidth-1:0] rsAddr;
    logic [regAddrWidth-1:0] rtAddr;
    logic [dataWidth-1:0]    rsData;
    logic [dataWidth-1:0]    rtData;

    logic [dataWidth-1:0]    aluA;
    logic [dataWidth-1:0]    aluB;
    logic [4:0]              shamt;
    aluOpT                   aluOp;
    logic [dataWidth-1:0]    aluResult;
    logic                    aluZero;

    logic [regAddrWidth-1:0] destReg;
    logic                    regWrite;
    logic                    isLoad;
    logic                    isStore;
    logic                    isBranchEq;
    logic                    isBranchNe;
    logic                    isJump;
    logic                    isJumpReg;
    logic [dataWidth-1:0]    branchOffset;
    logic [27:0]             jumpTarget;

    logic                    wrEn;
    logic [regAddrWidth-1:0] wrAddr;
    logic [dataWidth-1:0]    wrData;

    cpuController #(
        .resetVector(resetVector)
    ) u_cpuController (
        .clk(clk), .reset(reset),
        .waitrequest(waitrequest), .readdata(readdata),
        .address(address), .read(read), .write(write),
        .writedata(writedata), .byteenable(byteenable), .active(active),
        .instr(instr),
        .aluResult(aluResult), .aluZero(aluZero),
        .rtData(rtData), .rsData(rsData),
        .isLoad(isLoad), .isStore(isStore),
        .isBranchEq(isBranchEq), .isBranchNe(isBranchNe),
        .isJump(isJump), .isJumpReg(isJumpReg), .regWrite(regWrite),
        .destReg(destReg), .branchOffset(branchOffset), .jumpTarget(jumpTarget),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
    );

    instrDecoder u_instrDecoder (
        .instr(instr), .rsData(rsData), .rtData(rtData),
        .rsAddr(rsAddr), .rtAddr(rtAddr),
        .aluA(aluA), .aluB(aluB), .shamt(shamt), .aluOp(aluOp),
        .destReg(destReg), .regWrite(regWrite),
        .isLoad(isLoad), .isStore(isStore),
        .isBranchEq(isBranchEq), .isBranchNe(isBranchNe),
        .isJump(isJump), .isJumpReg(isJumpReg),
        .branchOffset(branchOffset), .jumpTarget(jumpTarget)
    );

    registerFile u_registerFile (
        .clk(clk), .reset(reset),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .rsAddr(rsAddr), .rtAddr(rtAddr),
        .rsData(rsData), .rtData(rtData),
        .registerV0(registerV0)
    );

    alu u_alu (
        .aluOp(aluOp), .aluA(aluA), .aluB(aluB), .shamt(shamt),
        .aluResult(aluResult), .aluZero(aluZero)
    );

endmodule

// File: hdl/mipsPkg.sv
package mipsPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;

    localparam logic [regAddrWidth-1:0] regZero = 5'd0;
    localparam logic [regAddrWidth-1:0] regV0 = 5'd2;

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        opRType = 6'b000000,
        opJ     = 6'b000010,
        opBeq   = 6'b000100,
        opBne   = 6'b000101,
        opAddiu = 6'b001001,
        opSlti  = 6'b001010,
        opSltiu = 6'b001011,
        opAndi  = 6'b001100,
        opOri   = 6'b001101,
        opXori  = 6'b001110,
        opLui   = 6'b001111,
        opLw    = 6'b100011,
        opSw    = 6'b101011
    } opcodeT;

    // Function field of R-type, instr[5:0]
    typedef enum logic [5:0] {
        fnSll  = 6'b000000,
        fnSrl  = 6'b000010,
        fnSra  = 6'b000011,
        fnJr   = 6'b001000,
        fnAddu = 6'b100001,
        fnSubu = 6'b100011,
        fnAnd  = 6'b100100,
        fnOr   = 6'b100101,
        fnXor  = 6'b100110,
        fnSlt  = 6'b101010,
        fnSltu = 6'b101011
    } funcT;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSlt   = 4'd5,
        aluSltu  = 4'd6,
        aluSll   = 4'd7,
        aluSrl   = 4'd8,
        aluSra   = 4'd9,
        aluLui   = 4'd10,
        aluPassA = 4'd11
    } aluOpT;

    typedef enum logic [2:0] {
        sFetch     = 3'b000,
        sDecode    = 3'b001,
        sExec      = 3'b010,
        sMem       = 3'b011,
        sWriteback = 3'b100,
        sHalted    = 3'b111
    } cpuStateT;

endpackage

// File: hdl/registerFile.sv
module registerFile
    import mipsPkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wrEn,
    input  logic [regAddrWidth-1:0] wrAddr,
    input  logic [dataWidth-1:0]    wrData,
    input  logic [regAddrWidth-1:0] rsAddr,
    input  logic [regAddrWidth-1:0] rtAddr,

    output logic [dataWidth-1:0]    rsData,
    output logic [dataWidth-1:0]    rtData,
    output logic [dataWidth-1:0]    registerV0
);

    logic [dataWidth-1:0] regs [2**regAddrWidth];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != regZero) begin
            regs[wrAddr] <= wrData;
        end
    end

    // $zero is never written, so it reads back as zero
    assign rsData = regs[rsAddr];
    assign rtData = regs[rtAddr];
    assign registerV0 = regs[regV0];

endmodule

// File: mipsCpu.f
hdl/mipsPkg.sv
hdl/alu.sv
hdl/registerFile.sv
hdl/instrDecoder.sv
hdl/cpuController.sv
hdl/mipsCpuBus.sv
dv/avalonMemModel.sv
dv/mipsCpuBusTb.sv
